//--- filelist.f
src/xbar_pkg.sv
src/xbar_decode.sv
src/xbar_execute.sv
src/xbar_result.sv
src/xbar_top.sv
verif/xbar_slave_model.sv
verif/xbar_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the crossbar testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module xbar_tb -f filelist.f -o xbar_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/xbar_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

grep -q "Test completed successfully" sim.log
if [ $? -ne 0 ]; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0

//--- src/xbar_decode.sv
// per-master slave decode and read ordering guard; one instance per master in the crossbar top.
`timescale 1ns/10ps

module xbar_decode
(
	input  logic               memread_grant,
	input  logic               rst_n_i,
	input  logic               req_i,
	input  xbar_pkg::addr_t    addr_i,
	input  logic               we_i,
	input  logic               ack_i,
	input  logic               resp_i,
	output logic               req_o,
	output xbar_pkg::port_id_t slave_o
);

	import xbar_pkg::*;

	dec_state_t  state;
	dec_state_t  state_nxt;
	outstd_cnt_t open_cnt;
	outstd_cnt_t cnt_nxt;
	port_id_t    open_slave;	// target of the open reads.
	port_id_t    sel_slave;
	logic        hold_order;
	logic        hold_limit;
	logic        rd_accept;

	assign sel_slave = addr_i[ADDR_W-1:SEL_LSB];
	assign slave_o   = sel_slave;

	// other slave while reads are open would reorder responses.
	assign hold_order = (state == DEC_READS_OPEN) && (open_slave != sel_slave);
	assign hold_limit = (open_cnt == outstd_cnt_t'(XBAR_OUTSTD_MAX));
	assign req_o      = req_i & ~hold_order & ~hold_limit;

	assign rd_accept = ack_i & ~we_i;	// writes leave the count alone.

	always_comb
	begin
		case ({rd_accept, resp_i})
			2'b10:   cnt_nxt = open_cnt + outstd_cnt_t'(1);
			2'b01:   cnt_nxt = open_cnt - outstd_cnt_t'(1);
			default: cnt_nxt = open_cnt;	// none, or one in and one out.
		endcase
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			DEC_FREE:       if (rd_accept) state_nxt = DEC_READS_OPEN;
			DEC_READS_OPEN: if (cnt_nxt == '0) state_nxt = DEC_FREE;
			default:        state_nxt = DEC_FREE;
		endcase
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			state      <= DEC_FREE;
			open_cnt   <= '0;
			open_slave <= '0;
		end
		else
		begin
			state    <= state_nxt;
			open_cnt <= cnt_nxt;
			if (rd_accept)
				open_slave <= sel_slave;
		end
	end

endmodule

//--- src/xbar_execute.sv
// per-slave round-robin arbiter; forwards the chosen master's request and steers the slave ack back.
`timescale 1ns/10ps

module xbar_execute
(
	input  logic               memread_grant,
	input  logic               rst_n_i,

	// master side, already qualified for this slave.
	input  logic               req_i     [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::addr_t    addr_i    [xbar_pkg::XBAR_PORTS],
	input  logic               we_i      [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::data_t    wdata_i   [xbar_pkg::XBAR_PORTS],
	output logic               ack_o     [xbar_pkg::XBAR_PORTS],

	// slave side.
	output logic               s_req_o,
	output xbar_pkg::addr_t    s_addr_o,
	output logic               s_we_o,
	output xbar_pkg::data_t    s_wdata_o,
	output xbar_pkg::port_id_t s_reqtid_o,
	input  logic               s_ack_i
);

	import xbar_pkg::*;

	port_id_t rr_ptr;	// first master looked at.
	port_id_t scan_id;
	port_id_t gnt_id;
	logic     gnt_vld;
	logic     gnt_ack;

	// ----------------------------------------------------------------------
	// round-robin scan
	// ----------------------------------------------------------------------

	always_comb
	begin
		gnt_vld = 1'b0;
		gnt_id  = rr_ptr;
		scan_id = rr_ptr;
		for (int i = 0; i < XBAR_PORTS; i++)
		begin
			scan_id = rr_ptr + port_id_t'(i);	// wraps at XBAR_PORTS.
			if (!gnt_vld && req_i[scan_id])
			begin
				gnt_vld = 1'b1;
				gnt_id  = scan_id;
			end
		end
	end

	// ----------------------------------------------------------------------
	// request mux and ack steering
	// ----------------------------------------------------------------------

	assign s_req_o    = gnt_vld;
	assign s_addr_o   = addr_i[gnt_id];
	assign s_we_o     = we_i[gnt_id];
	assign s_wdata_o  = wdata_i[gnt_id];
	assign s_reqtid_o = gnt_id;	// master number is the tid.

	assign gnt_ack = s_ack_i & gnt_vld;

	always_comb
	begin
		for (int m = 0; m < XBAR_PORTS; m++)
			ack_o[m] = gnt_ack && (gnt_id == port_id_t'(m));
	end

	// pointer moves past the master just served.
	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
			rr_ptr <= '0;
		else if (gnt_ack)
			rr_ptr <= gnt_id + port_id_t'(1);
	end

endmodule

//--- src/xbar_pkg.sv
// shared widths, port count and decode state of the memory bus crossbar; imported by every block.

package xbar_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------

	localparam int XBAR_PORTS      = 4;	// masters, and equally slaves.
	localparam int XBAR_OUTSTD_MAX = 4;	// open reads per master.

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int PORT_W = 2;	// log2 of XBAR_PORTS.
	localparam int CNT_W  = 3;	// holds 0 up to XBAR_OUTSTD_MAX.

	// slave select sits in the top address bits.
	localparam int SEL_LSB = ADDR_W - PORT_W;

	// ----------------------------------------------------------------------
	// types
	// ----------------------------------------------------------------------

	// byte address, passed through to the slave unchanged.
	typedef logic [ADDR_W-1:0] addr_t;

	// read and write data word.
	typedef logic [DATA_W-1:0] data_t;

	// master or slave number.
	// doubles as transaction id and as slave select.
	typedef logic [PORT_W-1:0] port_id_t;

	// count of open reads of one master.
	typedef logic [CNT_W-1:0] outstd_cnt_t;

	// read ordering state of one master.
	typedef enum logic
	{
		DEC_FREE,	// nothing open.
		DEC_READS_OPEN	// reads open to one known slave.
	} dec_state_t;

endpackage

//--- src/xbar_result.sv
// response return path; registers each slave response into the slot of the master named by its tid.
`timescale 1ns/10ps

module xbar_result
(
	input  logic               memread_grant,
	input  logic               rst_n_i,

	input  logic               s_resp_i    [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::port_id_t s_resptid_i [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::data_t    s_rdata_i   [xbar_pkg::XBAR_PORTS],

	output logic               m_resp_o    [xbar_pkg::XBAR_PORTS],
	output xbar_pkg::data_t    m_rdata_o   [xbar_pkg::XBAR_PORTS]
);

	import xbar_pkg::*;

	logic  hit_nxt   [XBAR_PORTS];
	data_t rdata_nxt [XBAR_PORTS];

	// at most one slave per master answers at a time.
	// the decode ordering guard keeps it so.
	always_comb
	begin
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			hit_nxt[m]   = 1'b0;
			rdata_nxt[m] = s_rdata_i[0];
			for (int s = 0; s < XBAR_PORTS; s++)
			begin
				if (s_resp_i[s] && (s_resptid_i[s] == port_id_t'(m)))
				begin
					hit_nxt[m]   = 1'b1;
					rdata_nxt[m] = s_rdata_i[s];
				end
			end
		end
	end

	always_ff @(posedge memread_grant or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			for (int m = 0; m < XBAR_PORTS; m++)
				m_resp_o[m] <= 1'b0;
		end
		else
		begin
			for (int m = 0; m < XBAR_PORTS; m++)
				m_resp_o[m] <= hit_nxt[m];	// one-cycle strobe.
		end
	end

	always_ff @(posedge memread_grant)
	begin
		for (int m = 0; m < XBAR_PORTS; m++)
			if (hit_nxt[m])
				m_rdata_o[m] <= rdata_nxt[m];
	end

endmodule

//--- src/xbar_top.sv
// four-master, four-slave memory bus crossbar; the block a system or testbench instantiates.
`timescale 1ns/10ps

module xbar_top
(
	input  logic               memread_grant,
	input  logic               rst_n_i,

	// ----------------------------------------------------------------------
	// master side
	// ----------------------------------------------------------------------
	input  logic               m_req_i     [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::addr_t    m_addr_i    [xbar_pkg::XBAR_PORTS],
	input  logic               m_we_i      [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::data_t    m_wdata_i   [xbar_pkg::XBAR_PORTS],
	output logic               m_ack_o     [xbar_pkg::XBAR_PORTS],
	output logic               m_resp_o    [xbar_pkg::XBAR_PORTS],
	output xbar_pkg::data_t    m_rdata_o   [xbar_pkg::XBAR_PORTS],

	// ----------------------------------------------------------------------
	// slave side
	// ----------------------------------------------------------------------
	output logic               s_req_o     [xbar_pkg::XBAR_PORTS],
	output xbar_pkg::addr_t    s_addr_o    [xbar_pkg::XBAR_PORTS],
	output logic               s_we_o      [xbar_pkg::XBAR_PORTS],
	output xbar_pkg::data_t    s_wdata_o   [xbar_pkg::XBAR_PORTS],
	output xbar_pkg::port_id_t s_reqtid_o  [xbar_pkg::XBAR_PORTS],
	input  logic               s_ack_i     [xbar_pkg::XBAR_PORTS],
	input  logic               s_resp_i    [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::port_id_t s_resptid_i [xbar_pkg::XBAR_PORTS],
	input  xbar_pkg::data_t    s_rdata_i   [xbar_pkg::XBAR_PORTS]
);

	import xbar_pkg::*;

	logic                  dec_req   [XBAR_PORTS];
	port_id_t              dec_slave [XBAR_PORTS];
	logic                  exe_req   [XBAR_PORTS][XBAR_PORTS];	// [slave][master].
	logic                  exe_ack   [XBAR_PORTS][XBAR_PORTS];	// [slave][master].
	logic [XBAR_PORTS-1:0] ack_vec   [XBAR_PORTS];	// per master, one bit per slave.

	for (genvar gm = 0; gm < XBAR_PORTS; gm++)
	begin : g_master
		xbar_decode u_decode
		(
			.memread_grant (memread_grant),
			.rst_n_i       (rst_n_i),
			.req_i         (m_req_i[gm]),
			.addr_i        (m_addr_i[gm]),
			.we_i          (m_we_i[gm]),
			.ack_i         (m_ack_o[gm]),
			.resp_i        (m_resp_o[gm]),
			.req_o         (dec_req[gm]),
			.slave_o       (dec_slave[gm])
		);

		for (genvar gs = 0; gs < XBAR_PORTS; gs++)
		begin : g_match
			assign exe_req[gs][gm] = dec_req[gm] & (dec_slave[gm] == port_id_t'(gs));
			assign ack_vec[gm][gs] = exe_ack[gs][gm];
		end

		assign m_ack_o[gm] = |ack_vec[gm];	// only one slave can ack.
	end

	for (genvar gs = 0; gs < XBAR_PORTS; gs++)
	begin : g_slave
		xbar_execute u_execute
		(
			.memread_grant (memread_grant),
			.rst_n_i       (rst_n_i),
			.req_i         (exe_req[gs]),
			.addr_i        (m_addr_i),
			.we_i          (m_we_i),
			.wdata_i       (m_wdata_i),
			.ack_o         (exe_ack[gs]),
			.s_req_o       (s_req_o[gs]),
			.s_addr_o      (s_addr_o[gs]),
			.s_we_o        (s_we_o[gs]),
			.s_wdata_o     (s_wdata_o[gs]),
			.s_reqtid_o    (s_reqtid_o[gs]),
			.s_ack_i       (s_ack_i[gs])
		);
	end

	xbar_result u_result
	(
		.memread_grant (memread_grant),
		.rst_n_i       (rst_n_i),
		.s_resp_i      (s_resp_i),
		.s_resptid_i   (s_resptid_i),
		.s_rdata_i     (s_rdata_i),
		.m_resp_o      (m_resp_o),
		.m_rdata_o     (m_rdata_o)
	);

endmodule

//--- verif/xbar_slave_model.sv
// behavioral memory slave for the crossbar testbench; one instance sits on each slave port.
`timescale 1ns/10ps

module xbar_slave_model
(
	input  logic               memread_grant,
	input  logic               rst_n_i,
	input  xbar_pkg::port_id_t slave_id_i,
	input  logic               hold_i,	// stalls responses.
	input  logic               req_i,
	input  xbar_pkg::addr_t    addr_i,
	input  logic               we_i,
	input  xbar_pkg::data_t    wdata_i,
	input  xbar_pkg::port_id_t reqtid_i,
	output logic               ack_o,
	output logic               resp_o,
	output xbar_pkg::port_id_t resptid_o,
	output xbar_pkg::data_t    rdata_o
);

	import xbar_pkg::*;

	data_t    mem [addr_t];	// sparse, unwritten words read the fill.
	port_id_t q_tid [$];
	data_t    q_data [$];
	int       q_due [$];
	int       q_cnt = 0;
	int       cyc = 0;

	initial
	begin
		resp_o    = 1'b0;
		resptid_o = '0;
		rdata_o   = '0;
	end

	assign ack_o = req_i && (q_cnt < 4);

	always @(posedge memread_grant)
	begin
		logic     take;
		logic     n_resp;
		port_id_t n_tid;
		data_t    n_data;
		take   = ack_o;
		n_resp = 1'b0;
		n_tid  = '0;
		n_data = '0;
		if (!rst_n_i)
		begin
			q_tid.delete();
			q_data.delete();
			q_due.delete();
		end
		else
		begin
			cyc++;
			if (take && we_i)
				mem[addr_i] = wdata_i;
			else if (take)
			begin
				q_tid.push_back(reqtid_i);
				q_data.push_back(mem.exists(addr_i) ? mem[addr_i] :
					{slave_id_i, addr_i[29:0]});
				q_due.push_back(cyc + int'($urandom_range(1, 4)));
			end
			// in order, head only.
			if (!hold_i && (q_tid.size() > 0) && (q_due[0] <= cyc))
			begin
				n_resp = 1'b1;
				n_tid  = q_tid.pop_front();
				n_data = q_data.pop_front();
				void'(q_due.pop_front());
			end
		end
		#1;
		q_cnt     = q_tid.size();
		resp_o    = n_resp;
		resptid_o = n_tid;
		rdata_o   = n_data;
	end

endmodule

//--- verif/xbar_tb.sv
// testbench for the crossbar top level; run it as the simulation top with four slave models.
`timescale 1ns/10ps

module xbar_tb;

	import xbar_pkg::*;

	localparam int SEED      = 18620;
	localparam int HALF_PER  = 50;
	localparam int ACK_WAIT  = 50;	// cycles.
	localparam int RESP_WAIT = 100;

	logic     clk;
	logic     rst_n;
	logic     m_req [XBAR_PORTS];
	logic     m_we [XBAR_PORTS];
	logic     m_ack [XBAR_PORTS];
	logic     m_resp [XBAR_PORTS];
	addr_t    m_addr [XBAR_PORTS];
	data_t    m_wdata [XBAR_PORTS];
	data_t    m_rdata [XBAR_PORTS];
	logic     s_req [XBAR_PORTS];
	logic     s_we [XBAR_PORTS];
	logic     s_ack [XBAR_PORTS];
	logic     s_resp [XBAR_PORTS];
	addr_t    s_addr [XBAR_PORTS];
	data_t    s_wdata [XBAR_PORTS];
	data_t    s_rdata [XBAR_PORTS];
	port_id_t s_reqtid [XBAR_PORTS];
	port_id_t s_resptid [XBAR_PORTS];
	logic     hold [XBAR_PORTS];

	logic [3:0] s_req_v;
	logic [3:0] m_ack_v;
	logic [3:0] m_req_v;
	logic [3:0] m_resp_v;
	logic [3:0] exp_resp_q;
	logic [3:0] order_bad;
	logic [3:0] limit_bad;
	data_t      exp_rdata_q [XBAR_PORTS];
	logic       collide;
	logic       rst_q1;
	logic       rst_q2;
	int         pend [XBAR_PORTS];
	port_id_t   pend_slave [XBAR_PORTS];
	data_t      rx_data [XBAR_PORTS][64];
	int         rx_cnt [XBAR_PORTS];
	int         grants [XBAR_PORTS];	// acks seen per master.
	int         err_cnt = 0;
	int         tests_run = 0;
	int         tests_bad = 0;

	xbar_top UUT
	(
		.memread_grant (clk),
		.rst_n_i       (rst_n),
		.m_req_i       (m_req),
		.m_addr_i      (m_addr),
		.m_we_i        (m_we),
		.m_wdata_i     (m_wdata),
		.m_ack_o       (m_ack),
		.m_resp_o      (m_resp),
		.m_rdata_o     (m_rdata),
		.s_req_o       (s_req),
		.s_addr_o      (s_addr),
		.s_we_o        (s_we),
		.s_wdata_o     (s_wdata),
		.s_reqtid_o    (s_reqtid),
		.s_ack_i       (s_ack),
		.s_resp_i      (s_resp),
		.s_resptid_i   (s_resptid),
		.s_rdata_i     (s_rdata)
	);

	for (genvar gs = 0; gs < XBAR_PORTS; gs++)
	begin : g_mem
		xbar_slave_model u_mem
		(
			.memread_grant (clk),
			.rst_n_i       (rst_n),
			.slave_id_i    (port_id_t'(gs)),
			.hold_i        (hold[gs]),
			.req_i         (s_req[gs]),
			.addr_i        (s_addr[gs]),
			.we_i          (s_we[gs]),
			.wdata_i       (s_wdata[gs]),
			.reqtid_i      (s_reqtid[gs]),
			.ack_o         (s_ack[gs]),
			.resp_o        (s_resp[gs]),
			.resptid_o     (s_resptid[gs]),
			.rdata_o       (s_rdata[gs])
		);
	end

	always #HALF_PER clk = ~clk;

	// ----------------------------------------------------------------------
	// reference state for the checks
	// ----------------------------------------------------------------------

	always_comb
	begin
		collide = 1'b0;
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			s_req_v[m]   = s_req[m];
			m_ack_v[m]   = m_ack[m];
			m_req_v[m]   = m_req[m];
			m_resp_v[m]  = m_resp[m];
			order_bad[m] = m_ack[m] && !m_we[m] && (pend[m] > 0)
				&& (m_addr[m][31:30] != pend_slave[m]);
			limit_bad[m] = m_ack[m] && !m_we[m] && (pend[m] >= XBAR_OUTSTD_MAX);
			for (int k = m + 1; k < XBAR_PORTS; k++)
				if (m_ack[m] && m_ack[k] && (m_addr[m][31:30] == m_addr[k][31:30]))
					collide = 1'b1;
		end
	end

	always @(posedge clk)
	begin
		rst_q1 <= rst_n;
		rst_q2 <= rst_q1;
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			exp_resp_q[m] <= 1'b0;
			for (int s = 0; s < XBAR_PORTS; s++)
				if (s_resp[s] && (s_resptid[s] == port_id_t'(m)))
				begin
					exp_resp_q[m]  <= 1'b1;
					exp_rdata_q[m] <= s_rdata[s];
				end
			if (!rst_n)
				pend[m] <= 0;
			else
				pend[m] <= pend[m] + int'(m_ack[m] && !m_we[m]) - int'(m_resp[m]);
			if (m_ack[m] && !m_we[m])
				pend_slave[m] <= m_addr[m][31:30];
		end
	end

	always @(negedge clk)
		for (int m = 0; m < XBAR_PORTS; m++)
			if (m_resp[m])
			begin
				rx_data[m][rx_cnt[m]] = m_rdata[m];
				rx_cnt[m]++;
			end

	// ----------------------------------------------------------------------
	// checks, sampled at the falling edge
	// ----------------------------------------------------------------------

	a_rst_sreq: assert property (@(negedge clk) !rst_q2 |-> s_req_v == 4'b0)
		else
		begin
			err_cnt++;
			$display("Error: %0t s_req_o exp 0000 got %b", $time, s_req_v);
		end
	a_rst_ack: assert property (@(negedge clk) !rst_q2 |-> m_ack_v == 4'b0)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_ack_o exp 0000 got %b", $time, m_ack_v);
		end
	a_rst_resp: assert property (@(negedge clk) !rst_q2 |-> m_resp_v == 4'b0)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_resp_o exp 0000 got %b", $time, m_resp_v);
		end
	a_ack_req: assert property (@(negedge clk) (m_ack_v & ~m_req_v) == 4'b0)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_ack_o exp %b got %b", $time, m_ack_v & m_req_v, m_ack_v);
		end
	a_one_ack: assert property (@(negedge clk) !collide)
		else
		begin
			err_cnt++;
			$display("two masters acked by one slave in a cycle at %0t", $time);
		end
	a_resp_lag: assert property (@(negedge clk) rst_q2 |-> m_resp_v == exp_resp_q)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_resp_o exp %b got %b", $time, exp_resp_q, m_resp_v);
		end
	a_order: assert property (@(negedge clk) order_bad == 4'b0)
		else
		begin
			err_cnt++;
			$display("read acked to a new slave with reads open, %0t", $time);
		end
	a_limit: assert property (@(negedge clk) limit_bad == 4'b0)
		else
		begin
			err_cnt++;
			$display("read acked beyond the outstanding limit at %0t", $time);
		end

	for (genvar gm = 0; gm < XBAR_PORTS; gm++)
	begin : g_rdata
		a_rdata: assert property (@(negedge clk) m_resp[gm] |-> m_rdata[gm] == exp_rdata_q[gm])
			else
			begin
				err_cnt++;
				$display("Error: %0t m_rdata_o[%0d] exp %h got %h",
					$time, gm, exp_rdata_q[gm], m_rdata[gm]);
			end
	end

	// ----------------------------------------------------------------------
	// master stimulus
	// ----------------------------------------------------------------------

	task automatic abort_run(input string what);
		$display("timeout waiting for %s at %0t", what, $time);
		$display("Test failed");
		$finish;
	endtask

	task automatic start_req(input int m, input addr_t a, input logic we, input data_t wd);
		@(posedge clk);
		#1;
		m_req[m]   = 1'b1;
		m_addr[m]  = a;
		m_we[m]    = we;
		m_wdata[m] = wd;
	endtask

	task automatic wait_ack(input int m);
		int n;
		n = 0;
		@(negedge clk);
		while (!m_ack[m])
		begin
			if (++n > ACK_WAIT)
				abort_run("an acknowledge");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		m_req[m] = 1'b0;
	endtask

	task automatic issue(input int m, input addr_t a, input logic we, input data_t wd);
		start_req(m, a, we, wd);
		wait_ack(m);
	endtask

	// tallies acks per master until total are seen, then drops every request.
	task automatic count_grants(input int total);
		int n;
		int seen;
		n    = 0;
		seen = 0;
		for (int m = 0; m < XBAR_PORTS; m++)
			grants[m] = 0;
		while (seen < total)
		begin
			if (++n > ACK_WAIT)
				abort_run("the arbitration grants");
			@(negedge clk);
			for (int m = 0; m < XBAR_PORTS; m++)
				if (m_ack[m])
				begin
					grants[m]++;
					seen++;
				end
		end
		@(posedge clk);
		#1;
		for (int m = 0; m < XBAR_PORTS; m++)
			m_req[m] = 1'b0;
	endtask

	task automatic wait_resp(input int m, input int cnt);
		int n;
		n = 0;
		while (rx_cnt[m] < cnt)
		begin
			if (++n > RESP_WAIT)
				abort_run("a read response");
			@(negedge clk);
		end
	endtask

	task automatic check_word(input int m, input int idx, input data_t exp);
		assert (rx_data[m][idx] == exp)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_rdata_o[%0d] exp %h got %h", $time, m, exp, rx_data[m][idx]);
		end
	endtask

	task automatic report(input string name, input int errs_before);
		tests_run++;
		if (err_cnt != errs_before)
			tests_bad++;
		$display("%s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial
	begin
		int    e;
		int    base;
		int    base_m [XBAR_PORTS];
		addr_t a;
		data_t wv;
		void'($urandom(SEED));
		clk   = 1'b0;
		rst_n = 1'b0;
		e     = err_cnt;
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			m_req[m] = 1'b0;
			m_addr[m] = '0;
			m_we[m] = 1'b0;
			m_wdata[m] = '0;
			hold[m] = 1'b0;
			rx_cnt[m] = 0;
		end
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		repeat (3) @(posedge clk);
		report("reset", e);

		e = err_cnt;	// each master reads the next slave region.
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			a = {2'((m + 1) % 4), 30'h100 + 30'(m * 4)};
			base = rx_cnt[m];
			issue(m, a, 1'b0, '0);
			wait_resp(m, base + 1);
			check_word(m, base, a);	// fill is the address itself.
		end
		report("decode", e);

		e = err_cnt;
		wv = $urandom;
		issue(2, 32'h4000_0200, 1'b1, wv);
		base = rx_cnt[3];
		issue(3, 32'h4000_0200, 1'b0, '0);
		wait_resp(3, base + 1);
		check_word(3, base, wv);
		report("write then read", e);

		e = err_cnt;	// all four masters keep requesting slave 2.
		for (int m = 0; m < XBAR_PORTS; m++)
			base_m[m] = rx_cnt[m];
		@(posedge clk);
		#1;
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			m_req[m]  = 1'b1;
			m_addr[m] = 32'h8000_0000 + 32'(m * 4);
			m_we[m]   = 1'b0;
		end
		count_grants(XBAR_PORTS);
		for (int m = 0; m < XBAR_PORTS; m++)
		begin
			assert (grants[m] == 1)
			else
			begin
				err_cnt++;
				$display("Error: %0t m_ack_o[%0d] count exp 1 got %0d", $time, m, grants[m]);
			end
			wait_resp(m, base_m[m] + 1);
			check_word(m, base_m[m], 32'h8000_0000 + 32'(m * 4));
		end
		report("arbitration", e);

		e = err_cnt;
		base = rx_cnt[0];
		for (int i = 0; i < 3; i++)
			issue(0, 32'h0000_0040 + 32'(i * 4), 1'b0, '0);
		issue(0, 32'h4000_0040, 1'b0, '0);
		assert (rx_cnt[0] == base + 3)
		else
		begin
			err_cnt++;
			$display("Error: %0t m_resp_o[0] count exp %0d got %0d", $time, 3, rx_cnt[0] - base);
		end
		wait_resp(0, base + 4);
		for (int i = 0; i < 3; i++)
			check_word(0, base + i, 32'h0000_0040 + 32'(i * 4));
		check_word(0, base + 3, 32'h4000_0040);
		report("ordering", e);

		e = err_cnt;
		@(posedge clk);
		#1 hold[3] = 1'b1;
		base = rx_cnt[1];
		for (int i = 0; i < 4; i++)
			issue(1, 32'hC000_0010 + 32'(i * 4), 1'b0, '0);
		start_req(1, 32'hC000_0020, 1'b0, '0);
		repeat (8)
		begin
			@(negedge clk);
			assert (!m_ack[1])
			else
			begin
				err_cnt++;
				$display("Error: %0t m_ack_o[1] exp 0 got %b", $time, m_ack[1]);
			end
			assert (!s_req[3])	// held in decode, not by the full slave.
			else
			begin
				err_cnt++;
				$display("Error: %0t s_req_o[3] exp 0 got %b", $time, s_req[3]);
			end
		end
		@(posedge clk);
		#1 hold[3] = 1'b0;
		wait_ack(1);
		wait_resp(1, base + 5);
		for (int i = 0; i < 5; i++)
			check_word(1, base + i, 32'hC000_0010 + 32'(i * 4));
		report("outstanding limit", e);

		repeat (2) @(posedge clk);
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_bad, err_cnt);
		if (err_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
